/* game_pkg.sv */
// Shared definitions for the arcade glue layer
// ROM and SDRAM address widths, data width, ROM client count
// Arbiter state and debug view selector enums

package game_pkg;

    // Default width of a client ROM address
    parameter int rom_aw = 16;

    // Default width of the SDRAM word address
    parameter int sdram_aw = 18;

    // ROM data width, one byte per read
    parameter int rom_dw = 8;

    // Main, sound and gfx
    parameter int n_clients = 3;

    // ROM arbiter FSM
    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_wait = 2'd1,
        arb_done = 2'd2
    } arb_state_t;

    // Debug view selector, taken from debug_bus[7:6]
    typedef enum logic [1:0] {
        dbg_status     = 2'd0,
        dbg_main_latch = 2'd1,
        dbg_snd_latch  = 2'd2,
        dbg_zero       = 2'd3
    } dbg_sel_t;

endpackage

/* rom_arbiter.sv */
// Round-robin ROM arbiter for the main, sound and gfx clients
// One SDRAM read in flight at a time, per-client hold registers
// Client ok is a live compare of the current address with the held one

`timescale 1ns/1ps

module rom_arbiter #(
    parameter int             AW        = game_pkg::rom_aw,
    parameter int             SAW       = game_pkg::sdram_aw,
    parameter logic [SAW-1:0] MAIN_BASE = '0,
    parameter logic [SAW-1:0] SND_BASE  = '0,
    parameter logic [SAW-1:0] GFX_BASE  = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        main_cs,
    input  logic [AW-1:0]               main_addr,
    output logic [game_pkg::rom_dw-1:0] main_data,
    output logic                        main_ok,

    input  logic                        snd_cs,
    input  logic [AW-1:0]               snd_addr,
    output logic [game_pkg::rom_dw-1:0] snd_data,
    output logic                        snd_ok,

    input  logic                        gfx_cs,
    input  logic [AW-1:0]               gfx_addr,
    output logic [game_pkg::rom_dw-1:0] gfx_data,
    output logic                        gfx_ok,

    output logic                        sdram_rd,
    output logic [SAW-1:0]              sdram_addr,
    input  logic                        sdram_rdy,
    input  logic [game_pkg::rom_dw-1:0] sdram_data
);

    localparam int NC = game_pkg::n_clients;
    localparam int IW = $clog2(NC);

    // Client order is main, snd, gfx
    localparam logic [SAW-1:0] BASE [NC] = '{MAIN_BASE, SND_BASE, GFX_BASE};

    game_pkg::arb_state_t state;

    logic [NC-1:0]               cs_v;
    logic [NC-1:0]               ok_v;
    logic [NC-1:0]               req;
    logic [NC-1:0]               gnt;
    logic [IW-1:0]               gnt_idx;
    logic [IW-1:0]               last_gnt;
    logic [AW-1:0]               addr_a    [NC];
    logic [AW-1:0]               req_addr;

    // Per-client hold registers
    logic [game_pkg::rom_dw-1:0] hold_data [NC];
    logic [AW-1:0]               hold_addr [NC];
    logic [NC-1:0]               hold_valid;

    assign cs_v   = {gfx_cs, snd_cs, main_cs};
    assign addr_a = '{main_addr, snd_addr, gfx_addr};

    always_comb begin
        for (int i = 0; i < NC; i++) begin
            ok_v[i] = cs_v[i] && hold_valid[i] && (hold_addr[i] == addr_a[i]);
        end
    end

    // A client asks for data while its held byte does not match
    assign req = cs_v & ~ok_v;

    // Rotating priority, search starts after the last grant
    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = last_gnt;
        for (int k = 1; k <= NC; k++) begin
            idx = (int'(last_gnt) + k) % NC;
            if (req[idx] && gnt == '0) begin
                gnt[idx] = 1'b1;
                gnt_idx  = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= game_pkg::arb_idle;
            last_gnt   <= IW'(NC - 1);
            sdram_rd   <= 1'b0;
            hold_valid <= '0;
        end else begin
            sdram_rd <= 1'b0;
            case (state)
                game_pkg::arb_idle: begin
                    if (|gnt) begin
                        state    <= game_pkg::arb_wait;
                        last_gnt <= gnt_idx;
                        sdram_rd <= 1'b1;
                    end
                end
                game_pkg::arb_wait: begin
                    if (sdram_rdy) begin
                        hold_valid[last_gnt] <= 1'b1;
                        state                <= game_pkg::arb_done;
                    end
                end
                default: state <= game_pkg::arb_idle;
            endcase
        end
    end

    // Address and data path
    always_ff @(posedge clk) begin
        if (state == game_pkg::arb_idle && |gnt) begin
            req_addr   <= addr_a[gnt_idx];
            sdram_addr <= BASE[gnt_idx] + SAW'(addr_a[gnt_idx]);
        end
        // Stored under the requested address, a moved client sees no ok
        if (state == game_pkg::arb_wait && sdram_rdy) begin
            hold_data[last_gnt] <= sdram_data;
            hold_addr[last_gnt] <= req_addr;
        end
    end

    assign main_data = hold_data[0];
    assign snd_data  = hold_data[1];
    assign gfx_data  = hold_data[2];
    assign main_ok   = ok_v[0];
    assign snd_ok    = ok_v[1];
    assign gfx_ok    = ok_v[2];

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt));

    // Read pulse only right after leaving idle
    a_rd_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_rd |-> (state == game_pkg::arb_wait) && ($past(state) == game_pkg::arb_idle));

    a_no_rdy_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(sdram_rdy && state == game_pkg::arb_idle));

endmodule

/* cpu_mailbox.sv */
// Two-way latch mailbox between the main and sound CPUs
// Strobe writes set a latch and its pending flag, acks clear the flag

`timescale 1ns/1ps

module cpu_mailbox (
    input  logic                        clk,
    input  logic                        rst_n,

    // Main to sound
    input  logic                        main_stb,
    input  logic [game_pkg::rom_dw-1:0] main_wdata,
    input  logic                        snd_ack,
    output logic [game_pkg::rom_dw-1:0] snd_latch,
    output logic                        snd_flag,

    // Sound to main
    input  logic                        snd_stb,
    input  logic [game_pkg::rom_dw-1:0] snd_wdata,
    input  logic                        main_ack,
    output logic [game_pkg::rom_dw-1:0] main_latch,
    output logic                        main_flag
);

    // Channel 0 carries main to sound, channel 1 sound to main
    logic                        stb   [2];
    logic [game_pkg::rom_dw-1:0] wdata [2];
    logic                        ack   [2];
    logic [game_pkg::rom_dw-1:0] latch [2];
    logic                        flag  [2];

    assign stb   = '{main_stb, snd_stb};
    assign wdata = '{main_wdata, snd_wdata};
    assign ack   = '{snd_ack, main_ack};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < 2; c++) begin
                latch[c] <= '0;
                flag[c]  <= 1'b0;
            end
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (stb[c]) begin
                    latch[c] <= wdata[c];
                end
                // Set beats clear
                if (stb[c]) begin
                    flag[c] <= 1'b1;
                end else if (ack[c]) begin
                    flag[c] <= 1'b0;
                end
            end
        end
    end

    assign snd_latch  = latch[0];
    assign snd_flag   = flag[0];
    assign main_latch = latch[1];
    assign main_flag  = flag[1];

    for (genvar c = 0; c < 2; c++) begin : g_chk
        a_latch_on_stb: assert property (@(posedge clk) disable iff (!rst_n)
            (latch[c] != $past(latch[c])) |-> $past(stb[c]));
    end

endmodule

/* board_config.sv */
// Board variant capture from the download header
// Sound CPU reset selection and registered debug view

`timescale 1ns/1ps

module board_config (
    input  logic                        clk,
    input  logic                        rst_n,

    // Download port
    input  logic                        prog_we,
    input  logic                        header,
    input  logic                        ioctl_addr,
    input  logic [game_pkg::rom_dw-1:0] prog_data,

    input  logic                        snd_rst,
    input  logic [7:0]                  debug_bus,
    input  logic [game_pkg::rom_dw-1:0] main_latch,
    input  logic [game_pkg::rom_dw-1:0] snd_latch,

    output logic                        tokio,
    output logic                        snd_rstn,
    output logic [7:0]                  debug_view
);

    game_pkg::dbg_sel_t sel;

    assign sel = game_pkg::dbg_sel_t'(debug_bus[7:6]);

    // Variant flag sits in bit 0 of the first header byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tokio <= 1'b0;
        end else if (prog_we && header && !ioctl_addr) begin
            tokio <= prog_data[0];
        end
    end

    // Only the tokio variant lets the main CPU hold the sound CPU in reset
    assign snd_rstn = tokio ? (rst_n & ~snd_rst) : rst_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_view <= '0;
        end else begin
            case (sel)
                game_pkg::dbg_status:     debug_view <= {2'b00, snd_rstn, snd_rst, 3'b000, tokio};
                game_pkg::dbg_main_latch: debug_view <= main_latch;
                game_pkg::dbg_snd_latch:  debug_view <= snd_latch;
                default:                  debug_view <= '0;
            endcase
        end
    end

endmodule

/* game_glue.sv */
// Glue layer top between main CPU, sound CPU and video
// ROM arbiter, CPU mailbox and board configuration
// Sets the address widths and the SDRAM region of each client

`timescale 1ns/1ps

module game_glue #(
    parameter int             AW        = game_pkg::rom_aw,
    parameter int             SAW       = game_pkg::sdram_aw,
    parameter logic [SAW-1:0] MAIN_BASE = 18'h0_0000,
    parameter logic [SAW-1:0] SND_BASE  = 18'h1_0000,
    parameter logic [SAW-1:0] GFX_BASE  = 18'h2_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // ROM clients
    input  logic                        main_cs,
    input  logic [AW-1:0]               main_addr,
    output logic [game_pkg::rom_dw-1:0] main_data,
    output logic                        main_ok,
    input  logic                        snd_cs,
    input  logic [AW-1:0]               snd_addr,
    output logic [game_pkg::rom_dw-1:0] snd_data,
    output logic                        snd_ok,
    input  logic                        gfx_cs,
    input  logic [AW-1:0]               gfx_addr,
    output logic [game_pkg::rom_dw-1:0] gfx_data,
    output logic                        gfx_ok,

    // SDRAM read port
    output logic                        sdram_rd,
    output logic [SAW-1:0]              sdram_addr,
    input  logic                        sdram_rdy,
    input  logic [game_pkg::rom_dw-1:0] sdram_data,

    // CPU mailbox
    input  logic                        main_stb,
    input  logic [game_pkg::rom_dw-1:0] main_wdata,
    input  logic                        main_ack,
    input  logic                        snd_stb,
    input  logic [game_pkg::rom_dw-1:0] snd_wdata,
    input  logic                        snd_ack,
    output logic [game_pkg::rom_dw-1:0] snd_latch,
    output logic                        snd_flag,
    output logic [game_pkg::rom_dw-1:0] main_latch,
    output logic                        main_flag,

    // Download header, sound reset and debug
    input  logic                        prog_we,
    input  logic                        header,
    input  logic                        ioctl_addr,
    input  logic [game_pkg::rom_dw-1:0] prog_data,
    input  logic                        snd_rst,
    input  logic [7:0]                  debug_bus,
    output logic                        tokio,
    output logic                        snd_rstn,
    output logic [7:0]                  debug_view
);

    rom_arbiter #(
        .AW        (AW),
        .SAW       (SAW),
        .MAIN_BASE (MAIN_BASE),
        .SND_BASE  (SND_BASE),
        .GFX_BASE  (GFX_BASE)
    ) u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .main_cs    (main_cs),
        .main_addr  (main_addr),
        .main_data  (main_data),
        .main_ok    (main_ok),
        .snd_cs     (snd_cs),
        .snd_addr   (snd_addr),
        .snd_data   (snd_data),
        .snd_ok     (snd_ok),
        .gfx_cs     (gfx_cs),
        .gfx_addr   (gfx_addr),
        .gfx_data   (gfx_data),
        .gfx_ok     (gfx_ok),
        .sdram_rd   (sdram_rd),
        .sdram_addr (sdram_addr),
        .sdram_rdy  (sdram_rdy),
        .sdram_data (sdram_data)
    );

    cpu_mailbox u_mailbox (
        .clk        (clk),
        .rst_n      (rst_n),
        .main_stb   (main_stb),
        .main_wdata (main_wdata),
        .snd_ack    (snd_ack),
        .snd_latch  (snd_latch),
        .snd_flag   (snd_flag),
        .snd_stb    (snd_stb),
        .snd_wdata  (snd_wdata),
        .main_ack   (main_ack),
        .main_latch (main_latch),
        .main_flag  (main_flag)
    );

    // Latches also feed the debug view
    board_config u_config (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_we    (prog_we),
        .header     (header),
        .ioctl_addr (ioctl_addr),
        .prog_data  (prog_data),
        .snd_rst    (snd_rst),
        .debug_bus  (debug_bus),
        .main_latch (main_latch),
        .snd_latch  (snd_latch),
        .tokio      (tokio),
        .snd_rstn   (snd_rstn),
        .debug_view (debug_view)
    );

endmodule

/* tb_rom_model.sv */
// SDRAM read model for the glue layer testbench
// Read latency of 1 to 6 cycles from an xorshift sequence
// Read data is the address folded down to one byte

`timescale 1ns/1ps

module tb_rom_model #(
    parameter int          SAW  = 18,
    parameter logic [31:0] SEED = 32'h1c98_cb10
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rd,
    input  logic [SAW-1:0] addr,
    output logic           rdy,
    output logic [7:0]     data
);

    logic [31:0]    rng;
    logic [SAW-1:0] addr_q;
    int             cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Low byte of the address XOR its upper bits
    function automatic logic [7:0] fold_byte(input logic [SAW-1:0] a);
        logic [31:0] w;
        w = 32'(a);
        w = w ^ (w >> 8) ^ (w >> 16) ^ (w >> 24);
        return w[7:0];
    endfunction

    // Outputs change on the falling edge, like every other DUT input
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rng  <= SEED;
            cnt  <= 0;
            rdy  <= 1'b0;
            data <= '0;
        end else begin
            rdy <= 1'b0;
            if (rd) begin
                rng    <= xorshift(rng);
                cnt    <= int'(xorshift(rng) % 6) + 1;
                addr_q <= addr;
            end else if (cnt != 0) begin
                // Last delay cycle, one-cycle ready pulse
                if (cnt == 1) begin
                    rdy  <= 1'b1;
                    data <= fold_byte(addr_q);
                end
                cnt <= cnt - 1;
            end
        end
    end

endmodule

/* tb_game_glue.sv */
// Testbench for the arcade glue layer
// Clock and reset, stimulus table applied in a loop, watchdog, summary line

`timescale 1ns/1ps

module tb_game_glue;

    localparam int             aw        = 16;
    localparam int             saw       = 18;
    localparam logic [saw-1:0] main_base = 18'h0_0000;
    localparam logic [saw-1:0] snd_base  = 18'h1_0000;
    localparam logic [saw-1:0] gfx_base  = 18'h2_0000;
    // Longest model delay plus arbiter overhead
    localparam int             max_txn   = 6 + 3;

    localparam int kind_read  = 0;
    localparam int kind_multi = 1;
    localparam int kind_hold  = 2;
    localparam int kind_move  = 3;
    localparam int kind_write = 4;
    localparam int kind_ack   = 5;
    localparam int kind_hdr   = 6;
    localparam int kind_srst  = 7;
    localparam int kind_dbg   = 8;

    logic           clk;
    logic           rst_n;
    logic           main_cs, snd_cs, gfx_cs;
    logic [aw-1:0]  main_addr, snd_addr, gfx_addr;
    logic [7:0]     main_data, snd_data, gfx_data;
    logic           main_ok, snd_ok, gfx_ok;
    logic           sdram_rd;
    logic [saw-1:0] sdram_addr;
    logic           sdram_rdy;
    logic [7:0]     sdram_data;
    logic           main_stb, snd_stb, main_ack, snd_ack;
    logic [7:0]     main_wdata, snd_wdata, snd_latch, main_latch;
    logic           snd_flag, main_flag;
    logic           prog_we, header, ioctl_addr, snd_rst, tokio, snd_rstn;
    logic [7:0]     prog_data, debug_bus, debug_view;

    // Stimulus table
    string          t_name   [$];
    int             t_kind   [$];
    int             t_client [$];
    logic [15:0]    t_val    [$];
    logic [1:0]     t_sel    [$];
    logic [7:0]     t_exp    [$];

    int n_steps  = 0;
    int errors   = 0;
    int checks   = 0;
    int cycle    = 0;
    int rd_count = 0;

    game_glue #(
        .AW        (aw),
        .SAW       (saw),
        .MAIN_BASE (main_base),
        .SND_BASE  (snd_base),
        .GFX_BASE  (gfx_base)
    ) dut0 (.*);

    tb_rom_model #(
        .SAW  (saw),
        .SEED (32'h1c98_cb10)
    ) rom0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (sdram_rd),
        .addr  (sdram_addr),
        .rdy   (sdram_rdy),
        .data  (sdram_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
    end

    always @(negedge clk) begin
        if (sdram_rd === 1'b1) begin
            rd_count++;
        end
    end

    function automatic logic [7:0] expected_byte(input logic [saw-1:0] a);
        logic [31:0] w;
        w = 32'(a);
        w = w ^ (w >> 8) ^ (w >> 16) ^ (w >> 24);
        return w[7:0];
    endfunction

    function automatic logic [saw-1:0] client_base(input int c);
        return c == 0 ? main_base : (c == 1 ? snd_base : gfx_base);
    endfunction

    function automatic logic client_ok(input int c);
        return c == 0 ? main_ok : (c == 1 ? snd_ok : gfx_ok);
    endfunction

    function automatic logic [7:0] client_data(input int c);
        return c == 0 ? main_data : (c == 1 ? snd_data : gfx_data);
    endfunction

    task automatic request(input int c, input logic [aw-1:0] a);
        case (c)
            0: begin
                main_cs   = 1'b1;
                main_addr = a;
            end
            1: begin
                snd_cs   = 1'b1;
                snd_addr = a;
            end
            default: begin
                gfx_cs   = 1'b1;
                gfx_addr = a;
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    // Poll on falling edges until ok rises or the limit runs out
    task automatic wait_ok(input int c, input int limit, input string name);
        int n = 0;
        while (!client_ok(c) && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (client_ok(c)) else begin
            errors++;
            $display("%s: ok of client %0d did not rise within %0d cycles", name, c, limit);
        end
    endtask

    task automatic add_step(input string name, input int kind, input int c,
                            input logic [15:0] val, input logic [1:0] sel,
                            input logic [7:0] exp);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_client.push_back(c);
        t_val.push_back(val);
        t_sel.push_back(sel);
        t_exp.push_back(exp);
    endtask

    task automatic run_step(input int i);
        int c;
        int start;
        int reads;
        c = t_client[i];
        case (t_kind[i])
            kind_read: begin
                request(c, t_val[i]);
                wait_ok(c, max_txn, t_name[i]);
                check_value(t_name[i], t_exp[i], client_data(c));
                check_value({t_name[i], " sdram addr"},
                            saw'(client_base(c) + saw'(t_val[i])), sdram_addr);
            end
            kind_multi: begin
                // All three ask in one cycle and queue up behind each other
                for (int k = 0; k < 3; k++) begin
                    request(k, t_val[i] + aw'(k));
                end
                // Old ok levels drop once the new addresses settle
                #1;
                start = cycle;
                for (int k = 0; k < 3; k++) begin
                    wait_ok(k, 3 * max_txn - (cycle - start), t_name[i]);
                    check_value(t_name[i],
                                expected_byte(client_base(k) + saw'(t_val[i]) + saw'(k)),
                                client_data(k));
                end
            end
            kind_hold: begin
                reads = rd_count;
                request(c, t_val[i]);
                repeat (5) @(negedge clk);
                check_value(t_name[i], t_exp[i], rd_count - reads);
                check_value({t_name[i], " ok"}, 1, client_ok(c));
            end
            kind_move: begin
                request(c, t_val[i]);
                #1;
                check_value({t_name[i], " drop"}, 0, client_ok(c));
                wait_ok(c, max_txn, t_name[i]);
                check_value(t_name[i], t_exp[i], client_data(c));
            end
            kind_write: begin
                // sel bit 0 adds a clear of the same flag in the same cycle
                if (c == 0) begin
                    main_stb   = 1'b1;
                    main_wdata = t_val[i][7:0];
                    snd_ack    = t_sel[i][0];
                end else begin
                    snd_stb   = 1'b1;
                    snd_wdata = t_val[i][7:0];
                    main_ack  = t_sel[i][0];
                end
                @(negedge clk);
                {main_stb, snd_stb, main_ack, snd_ack} = '0;
                check_value(t_name[i], t_exp[i], c == 0 ? snd_latch : main_latch);
                check_value({t_name[i], " flag"}, 1, c == 0 ? snd_flag : main_flag);
            end
            kind_ack: begin
                if (c == 0) begin
                    main_ack = 1'b1;
                end else begin
                    snd_ack = 1'b1;
                end
                @(negedge clk);
                {main_ack, snd_ack} = '0;
                check_value(t_name[i], t_exp[i], c == 0 ? main_flag : snd_flag);
            end
            kind_hdr: begin
                {prog_we, header, ioctl_addr} = 3'b110;
                prog_data = t_val[i][7:0];
                @(negedge clk);
                {prog_we, header} = 2'b00;
                check_value(t_name[i], t_exp[i], tokio);
            end
            kind_srst: begin
                snd_rst = t_val[i][0];
                #1;
                check_value(t_name[i], t_exp[i], snd_rstn);
            end
            default: begin
                debug_bus = {t_sel[i], 6'b0};
                @(negedge clk);
                check_value(t_name[i], t_exp[i], debug_view);
            end
        endcase
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        {main_cs, snd_cs, gfx_cs} = '0;
        {main_addr, snd_addr, gfx_addr} = '0;
        {main_stb, snd_stb, main_ack, snd_ack} = '0;
        {main_wdata, snd_wdata, prog_data} = '0;
        {prog_we, header, ioctl_addr, snd_rst} = '0;
        debug_bus = '0;

        add_step("main read", kind_read, 0, 16'h0123, 2'd0, expected_byte(main_base + 18'h0123));
        add_step("snd read", kind_read, 1, 16'h0456, 2'd0, expected_byte(snd_base + 18'h0456));
        add_step("gfx read", kind_read, 2, 16'hbeef, 2'd0, expected_byte(gfx_base + 18'hbeef));
        add_step("three reads", kind_multi, 0, 16'h2000, 2'd0, 8'h00);
        add_step("main same addr", kind_hold, 0, 16'h2000, 2'd0, 8'h00);
        add_step("main new addr", kind_move, 0, 16'h3344, 2'd0, expected_byte(main_base + 18'h3344));
        add_step("gfx new addr", kind_move, 2, 16'h0010, 2'd0, expected_byte(gfx_base + 18'h0010));
        add_step("main to snd", kind_write, 0, 16'h005a, 2'd0, 8'h5a);
        add_step("snd ack", kind_ack, 1, 16'h0000, 2'd0, 8'h00);
        add_step("snd to main", kind_write, 1, 16'h00c3, 2'd0, 8'hc3);
        add_step("main ack", kind_ack, 0, 16'h0000, 2'd0, 8'h00);
        add_step("snd to main with ack", kind_write, 1, 16'h003c, 2'd1, 8'h3c);
        add_step("main to snd with ack", kind_write, 0, 16'h00a5, 2'd1, 8'ha5);
        add_step("snd rst no tokio", kind_srst, 0, 16'h0001, 2'd0, 8'h01);
        add_step("header tokio", kind_hdr, 0, 16'h0001, 2'd0, 8'h01);
        add_step("snd rst tokio", kind_srst, 0, 16'h0001, 2'd0, 8'h00);
        // Status byte has snd_rstn in bit 5, snd_rst in bit 4, tokio in bit 0
        add_step("dbg status held", kind_dbg, 0, 16'h0000, 2'd0, 8'h11);
        add_step("snd rst release", kind_srst, 0, 16'h0000, 2'd0, 8'h01);
        add_step("dbg status run", kind_dbg, 0, 16'h0000, 2'd0, 8'h21);
        add_step("dbg main latch", kind_dbg, 0, 16'h0000, 2'd1, 8'h3c);
        add_step("dbg snd latch", kind_dbg, 0, 16'h0000, 2'd2, 8'ha5);
        add_step("dbg zero", kind_dbg, 0, 16'h0000, 2'd3, 8'h00);
        n_steps = t_name.size();

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            @(negedge clk);
            run_step(i);
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog scaled by the table length
    initial begin
        wait (n_steps > 0);
        repeat (n_steps * 40 + 200) @(posedge clk);
        $display("Timeout: steps did not finish within %0d cycles", n_steps * 40 + 200);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* all.f */
game_pkg.sv
rom_arbiter.sv
cpu_mailbox.sv
board_config.sv
game_glue.sv
tb_rom_model.sv
tb_game_glue.sv
